// File: source/imul_pkg.sv
/*
 * imul_pkg
 * Widths, sizes and payload types shared by the two-port
 * iterative integer multiply unit
 */
`default_nettype none

package imul_pkg;

  // Operand and product width
  localparam int imul_width       = 32;
  // Requester ports sharing the multiplier
  localparam int imul_ports       = 2;
  // Entries in every request and response queue
  localparam int imul_queue_depth = 2;

  // Derived sizes for queue pointers, queue count and step counter
  localparam int imul_qptr_bits   = $clog2(imul_queue_depth);
  localparam int imul_qcnt_bits   = $clog2(imul_queue_depth + 1);
  localparam int imul_step_bits   = $clog2(imul_width);

  typedef logic [$clog2(imul_ports)-1:0] imul_port_t;

  // One multiply request, a in the upper half
  typedef struct packed {
    logic [imul_width-1:0] a;
    logic [imul_width-1:0] b;
  } imul_req_t;

  // Low half of the product only
  typedef struct packed {
    logic [imul_width-1:0] product;
  } imul_resp_t;

  // Request and result tagged with the owning port
  typedef struct packed {
    imul_port_t port;
    imul_req_t  req;
  } imul_tag_req_t;

  typedef struct packed {
    imul_port_t port;
    imul_resp_t resp;
  } imul_tag_resp_t;

endpackage

`default_nettype wire

// File: source/imul_queue.sv
/*
 * imul_queue
 * Small FIFO with valid/ready on both sides, payload chosen by a
 * type parameter. Items show at the output from the cycle after
 * they are written; there is no bypass path.
 */
`timescale 1ns/100ps
`default_nettype none

module imul_queue
  import imul_pkg::*;
#(
  parameter type payload_t = imul_req_t
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_msg,
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_msg
);

  // Storage and circular pointers
  payload_t                  mem [imul_queue_depth];
  logic [imul_qptr_bits-1:0] wr_ptr;
  logic [imul_qptr_bits-1:0] rd_ptr;
  logic [imul_qcnt_bits-1:0] count;
  logic                      do_write;
  logic                      do_read;

  // Pointer advance with wrap at the last entry
  function automatic logic [imul_qptr_bits-1:0] ptr_inc(input logic [imul_qptr_bits-1:0] ptr);
    if (ptr == imul_qptr_bits'(imul_queue_depth - 1))
    begin
      return '0;
    end
    return ptr + imul_qptr_bits'(1);
  endfunction

  // Full and empty come straight from the count
  assign in_rdy   = (count != imul_qcnt_bits'(imul_queue_depth));
  assign out_val  = (count != '0);
  assign out_msg  = mem[rd_ptr];
  assign do_write = in_val && in_rdy;
  assign do_read  = out_val && out_rdy;

  // Payload storage
  always_ff @(posedge clk)
  begin
    if (do_write)
    begin
      mem[wr_ptr] <= in_msg;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_write)
      begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_read)
      begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leaves the count alone
      case ({do_write, do_read})
        2'b10:   count <= count + imul_qcnt_bits'(1);
        2'b01:   count <= count - imul_qcnt_bits'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/imul_port_arbiter.sv
/*
 * imul_port_arbiter
 * Round-robin choice between the request queues feeding the single
 * multiplier. Granted requests are tagged with their port; results
 * are steered back to the response queue named by the tag.
 */
`timescale 1ns/100ps
`default_nettype none

module imul_port_arbiter
  import imul_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  // Request queue outputs
  input  logic       [imul_ports-1:0] q_val,
  output logic       [imul_ports-1:0] q_rdy,
  input  imul_req_t  [imul_ports-1:0] q_msg,
  // Toward the multiplier
  output logic                        mul_val,
  input  logic                        mul_rdy,
  output imul_tag_req_t               mul_msg,
  // Results from the multiplier
  input  logic                        res_val,
  output logic                        res_rdy,
  input  imul_tag_resp_t              res_msg,
  // Response queue inputs
  output logic       [imul_ports-1:0] rsp_val,
  input  logic       [imul_ports-1:0] rsp_rdy,
  output imul_resp_t [imul_ports-1:0] rsp_msg
);

  imul_port_t last_grant;
  imul_port_t pref;
  imul_port_t other;
  imul_port_t grant;

  // --------------------------------------------------------------------------
  // Request side
  // --------------------------------------------------------------------------

  // Port not served last has priority
  assign pref  = ~last_grant;
  assign other = ~pref;
  // Preferred port if it has work, otherwise the other one
  assign grant = q_val[pref] ? pref : other;

  assign mul_val          = |q_val;
  assign mul_msg.port     = grant;
  assign mul_msg.req      = q_msg[grant];

  // Each ready looks only at the other queue's valid
  always_comb
  begin
    q_rdy        = '0;
    q_rdy[pref]  = mul_rdy;
    q_rdy[other] = mul_rdy && !q_val[pref];
  end

  // Remember who was served; reset value lets port 0 go first
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      last_grant <= imul_port_t'(imul_ports - 1);
    end
    else if (mul_val && mul_rdy)
    begin
      last_grant <= grant;
    end
  end

  // --------------------------------------------------------------------------
  // Result side
  // --------------------------------------------------------------------------

  // Valid only to the tagged port, payload fanned out to all
  always_comb
  begin
    for (int p = 0; p < imul_ports; p++)
    begin
      rsp_val[p] = res_val && (res_msg.port == imul_port_t'(p));
      rsp_msg[p] = res_msg.resp;
    end
  end

  // Stall the multiplier when the owning queue is full
  // (blocks the other port too, by design)
  assign res_rdy = rsp_rdy[res_msg.port];

endmodule

`default_nettype wire

// File: source/imul_iterative.sv
/*
 * imul_iterative
 * Shift-and-add multiplier, one bit of b per cycle. Finishes early
 * once the remaining bits of b are zero. Only the low half of the
 * product is kept, so two's-complement wraparound gives the signed
 * result with no sign handling. The port tag rides along.
 */
`timescale 1ns/100ps
`default_nettype none

module imul_iterative
  import imul_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_val,
  output logic           in_rdy,
  input  imul_tag_req_t  in_msg,
  output logic           out_val,
  input  logic           out_rdy,
  output imul_tag_resp_t out_msg
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t                    state;
  logic [imul_step_bits-1:0] step;
  logic [imul_width-1:0]     a_reg;
  logic [imul_width-1:0]     b_reg;
  logic [imul_width-1:0]     b_next;
  logic [imul_width-1:0]     acc;
  imul_port_t                port_reg;
  logic                      last_step;

  // Handshake straight from the state
  assign in_rdy  = (state == st_idle);
  assign out_val = (state == st_done);

  assign out_msg.port         = port_reg;
  assign out_msg.resp.product = acc;

  // Stop when b runs out of ones or after the final bit
  assign b_next    = b_reg >> 1;
  assign last_step = (b_next == '0) || (step == imul_step_bits'(imul_width - 1));

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= st_idle;
      step  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (in_val)
          begin
            // b of zero needs no steps at all
            state <= (in_msg.req.b == '0) ? st_done : st_calc;
            step  <= '0;
          end
        end
        st_calc:
        begin
          step <= step + imul_step_bits'(1);
          if (last_step)
          begin
            state <= st_done;
          end
        end
        st_done:
        begin
          // Result held until taken
          if (out_rdy)
          begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (state == st_idle && in_val)
    begin
      a_reg    <= in_msg.req.a;
      b_reg    <= in_msg.req.b;
      acc      <= '0;
      port_reg <= in_msg.port;
    end
    else if (state == st_calc)
    begin
      // Add partial product for the current bit of b
      if (b_reg[0])
      begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_next;
    end
  end

endmodule

`default_nettype wire

// File: source/imul_top.sv
/*
 * imul_top
 * Two-port integer multiply unit. Per-port request queues feed a
 * round-robin arbiter into one iterative multiplier; results come
 * back through per-port response queues in request order.
 */
`timescale 1ns/100ps
`default_nettype none

module imul_top
  import imul_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic       [imul_ports-1:0] req_val,
  output logic       [imul_ports-1:0] req_rdy,
  input  imul_req_t  [imul_ports-1:0] req_msg,
  output logic       [imul_ports-1:0] resp_val,
  input  logic       [imul_ports-1:0] resp_rdy,
  output imul_resp_t [imul_ports-1:0] resp_msg
);

  // Request queues to arbiter
  logic           [imul_ports-1:0] q_val;
  logic           [imul_ports-1:0] q_rdy;
  imul_req_t      [imul_ports-1:0] q_msg;

  // Arbiter and multiplier
  logic                            mul_val;
  logic                            mul_rdy;
  imul_tag_req_t                   mul_msg;
  logic                            res_val;
  logic                            res_rdy;
  imul_tag_resp_t                  res_msg;

  // Arbiter to response queues
  logic           [imul_ports-1:0] rsp_val;
  logic           [imul_ports-1:0] rsp_rdy;
  imul_resp_t     [imul_ports-1:0] rsp_msg;

  // --------------------------------------------------------------------------
  // Per-port queues
  // --------------------------------------------------------------------------

  for (genvar p = 0; p < imul_ports; p++)
  begin : g_port
    imul_queue #(.payload_t(imul_req_t)) req_q (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_val  (req_val[p]),
      .in_rdy  (req_rdy[p]),
      .in_msg  (req_msg[p]),
      .out_val (q_val[p]),
      .out_rdy (q_rdy[p]),
      .out_msg (q_msg[p])
    );

    imul_queue #(.payload_t(imul_resp_t)) resp_q (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_val  (rsp_val[p]),
      .in_rdy  (rsp_rdy[p]),
      .in_msg  (rsp_msg[p]),
      .out_val (resp_val[p]),
      .out_rdy (resp_rdy[p]),
      .out_msg (resp_msg[p])
    );
  end

  // --------------------------------------------------------------------------
  // Shared arbiter and multiplier
  // --------------------------------------------------------------------------

  imul_port_arbiter arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .q_val   (q_val),
    .q_rdy   (q_rdy),
    .q_msg   (q_msg),
    .mul_val (mul_val),
    .mul_rdy (mul_rdy),
    .mul_msg (mul_msg),
    .res_val (res_val),
    .res_rdy (res_rdy),
    .res_msg (res_msg),
    .rsp_val (rsp_val),
    .rsp_rdy (rsp_rdy),
    .rsp_msg (rsp_msg)
  );

  imul_iterative mul (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (mul_val),
    .in_rdy  (mul_rdy),
    .in_msg  (mul_msg),
    .out_val (res_val),
    .out_rdy (res_rdy),
    .out_msg (res_msg)
  );

endmodule

`default_nettype wire

// File: tb/imul_top_tb.sv
/*
 * imul_top_tb
 * Directed testbench for the two-port iterative multiply unit.
 * Drives both request ports, checks every product in per-port order
 * against a signed reference, and exercises response back-pressure.
 */
`timescale 1ns/100ps
`default_nettype none

module imul_top_tb
  import imul_pkg::*;
();

  // Requests over all tests, sizes the watchdog
  localparam int total_reqs      = 128;
  localparam int watchdog_cycles = total_reqs * 40 + 500;

  logic                        clk        = 1'b0;
  logic                        rst_n      = 1'b0;
  logic       [imul_ports-1:0] req_val    = '0;
  logic       [imul_ports-1:0] req_rdy;
  imul_req_t  [imul_ports-1:0] req_msg    = '0;
  logic       [imul_ports-1:0] resp_val;
  logic       [imul_ports-1:0] resp_rdy   = '1;
  imul_resp_t [imul_ports-1:0] resp_msg;

  // Sink ready control, fixed level or random per cycle
  logic       [imul_ports-1:0] rdy_hold   = '1;
  logic                        rdy_random = 1'b0;
  logic       [31:0]           rdy_rnd;

  integer     seed   = 32'h9d6f2e58;
  int         errors = 0;
  int         checks = 0;
  // Expected products per port, oldest first
  imul_resp_t exp_q0[$];
  imul_resp_t exp_q1[$];

  imul_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    rdy_rnd = $random(seed);
    resp_rdy <= rdy_random ? rdy_rnd[imul_ports-1:0] : rdy_hold;
  end

  // -------------------------------------------------------------------------
  // Reference model and compare tasks
  // -------------------------------------------------------------------------

  // Low half of the full signed product
  function automatic imul_resp_t ref_product(input imul_req_t req);
    longint     full;
    imul_resp_t r;
    full      = longint'($signed(req.a)) * longint'($signed(req.b));
    r.product = full[imul_width-1:0];
    return r;
  endfunction

  task automatic compare_resp(input string name, input imul_resp_t exp, input imul_resp_t act);
    checks++;
    if (act.product !== exp.product)
    begin
      errors++;
      $display("error: time %0t %s.product expected %h actual %h",
               $time, name, exp.product, act.product);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("error: time %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Pop the oldest expected product of a port and check it
  task automatic check_response(input int p, input imul_resp_t act);
    imul_resp_t exp;
    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0))
    begin
      errors++;
      $display("port %0d returned a response that no request asked for", p);
    end
    else
    begin
      exp = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      compare_resp($sformatf("resp_msg[%0d]", p), exp, act);
    end
  endtask

  // Per-port monitors, transfer seen at the edge where val and rdy are high
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      for (int p = 0; p < imul_ports; p++)
      begin
        if (resp_val[p] && resp_rdy[p])
        begin
          check_response(p, resp_msg[p]);
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Drivers
  // -------------------------------------------------------------------------

  // Called just after a rising edge, returns on the edge of the transfer
  task automatic send_req(input int p, input imul_req_t req, input int gap);
    req_val[p] <= 1'b1;
    req_msg[p] <= req;
    do
      @(posedge clk);
    while (!req_rdy[p]);
    if (p == 0)
    begin
      exp_q0.push_back(ref_product(req));
    end
    else
    begin
      exp_q1.push_back(ref_product(req));
    end
    if (gap > 0)
    begin
      req_val[p] <= 1'b0;
      repeat (gap) @(posedge clk);
    end
  endtask

  // Random operands; shifted b gives a spread of latencies
  task automatic drive_random(input int p, input int n, input bit gaps);
    imul_req_t req;
    int        tmp;
    int        shift;
    int        gap;
    for (int i = 0; i < n; i++)
    begin
      req.a = $random(seed);
      tmp   = $random(seed);
      shift = $unsigned($random(seed)) % imul_width;
      req.b = tmp >>> shift;
      gap   = gaps ? $unsigned($random(seed)) % 4 : 0;
      send_req(p, req, gap);
    end
    req_val[p] <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q0.size() != 0 || exp_q1.size() != 0)
    begin
      @(posedge clk);
    end
    // A few more edges so a stray response would show
    repeat (4) @(posedge clk);
  endtask

  // -------------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------------

  task automatic check_idle_outputs();
    for (int p = 0; p < imul_ports; p++)
    begin
      compare_bit($sformatf("resp_val[%0d]", p), 1'b0, resp_val[p]);
      compare_bit($sformatf("req_rdy[%0d]", p), 1'b1, req_rdy[p]);
    end
  endtask

  task automatic test_reset_state();
    // Sync reset takes hold at the first edge
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk);
      if (i >= 1)
      begin
        check_idle_outputs();
      end
    end
    rst_n <= 1'b1;
    repeat (2)
    begin
      @(posedge clk);
      check_idle_outputs();
    end
  endtask

  task automatic test_port0_edges();
    send_req(0, {32'd7, 32'd6}, 0);
    send_req(0, {32'd0, 32'd12345}, 0);
    send_req(0, {32'd12345, 32'd0}, 0);
    send_req(0, {32'd1, 32'hdeadbeef}, 0);
    send_req(0, {32'hffffffff, 32'd5}, 0);
    send_req(0, {32'd9, 32'hfffffffd}, 0);
    send_req(0, {32'hfffffffd, 32'hfffffffc}, 0);
    send_req(0, {32'h80000000, 32'hffffffff}, 0);
    req_val[0] <= 1'b0;
    wait_drain();
  endtask

  // Negative b runs all steps, positive b finishes early
  task automatic test_port1_large();
    send_req(1, {32'h7ff01234, 32'h0fedcba9}, 0);
    send_req(1, {32'h800fedcc, 32'h0fedcba9}, 0);
    send_req(1, {32'h7ff01234, 32'hf0123457}, 0);
    send_req(1, {32'h800fedcc, 32'hf0123457}, 0);
    req_val[1] <= 1'b0;
    wait_drain();
  endtask

  task automatic test_both_ports();
    fork
      drive_random(0, 12, 1'b1);
      drive_random(1, 12, 1'b1);
    join
    wait_drain();
  endtask

  task automatic test_back_pressure();
    logic saw_full;
    saw_full = 1'b0;
    rdy_hold[0] <= 1'b0;
    fork
      drive_random(0, 8, 1'b0);
      drive_random(1, 4, 1'b0);
      begin
        repeat (120)
        begin
          @(posedge clk);
          if (!req_rdy[0])
          begin
            saw_full = 1'b1;
          end
        end
        // Held result still waiting at the stalled port
        compare_bit("resp_val[0]", 1'b1, resp_val[0]);
        rdy_hold[0] <= 1'b1;
      end
    join
    if (!saw_full)
    begin
      errors++;
      $display("port 0 req_rdy never dropped while its responses were stalled");
    end
    wait_drain();
  endtask

  task automatic test_random_stress();
    rdy_random <= 1'b1;
    fork
      drive_random(0, 40, 1'b1);
      drive_random(1, 40, 1'b1);
    join
    rdy_random <= 1'b0;
    wait_drain();
  endtask

  initial
  begin
    test_reset_state();
    test_port0_edges();
    test_port1_large();
    test_both_ports();
    test_back_pressure();
    test_random_stress();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout after %0d cycles with responses still outstanding", watchdog_cycles);
    $display("checks: %0d errors: %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: imul_top.f
source/imul_pkg.sv
source/imul_queue.sv
source/imul_port_arbiter.sv
source/imul_iterative.sv
source/imul_top.sv
tb/imul_top_tb.sv
